// File: arith_unit.f
common/arith_fmt_pkg.sv
common/arith_ctrl_pkg.sv
mul/fx_mul_pipe.sv
div/div_core.sv
div/div_pipe.sv
src/arith_unit.sv
test/arith_unit_sva.sv
test/arith_unit_tb.sv

// File: common/arith_ctrl_pkg.sv
package arith_ctrl_pkg;

  typedef enum logic [2:0] {
    OP_MUL     = 3'd0,
    OP_FXMUL_U = 3'd1,
    OP_FXMUL_S = 3'd2,
    OP_DIV_U   = 3'd3,
    OP_DIV_S   = 3'd4
  } op_t;

  // Restoring divider sequence
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_RUN  = 2'd1,
    DIV_DONE = 2'd2
  } div_state_t;

endpackage

// File: common/arith_fmt_pkg.sv
package arith_fmt_pkg;

  // Operand and result width
  localparam int WORD_W = 16;

  // Q8.8 fixed-point format
  localparam int FRAC_W = 8;
  localparam int INT_W  = WORD_W - FRAC_W;

  // One quotient bit per divider step
  localparam int DIV_STEPS = WORD_W;

  // Clock edges from the start edge to done for a multiply
  localparam int MUL_LATENCY = 3;

  // Step counter must reach DIV_STEPS itself
  localparam int STEP_W = $clog2(DIV_STEPS + 1);

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [2*WORD_W-1:0] dword_t;
  typedef logic [STEP_W-1:0]   step_t;

endpackage

// File: div/div_core.sv
`timescale 1ns/1ps

module div_core
  import arith_fmt_pkg::*;
  import arith_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  go,
  input  word_t left,
  input  word_t right,
  output word_t quotient,
  output word_t rem,
  output logic  core_done
);

  div_state_t state;
  step_t      step;

  word_t  dividend;
  dword_t divisor;
  word_t  quo_mask;
  word_t  quo_acc;

  logic zero_div;
  logic load;
  logic last;
  logic fits;

  assign zero_div = (right == '0);
  assign load     = go && (state == DIV_IDLE);
  assign last     = (state == DIV_RUN) && (step == step_t'(DIV_STEPS));
  assign fits     = (dword_t'(dividend) >= divisor);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= DIV_IDLE;
      step      <= '0;
      core_done <= 1'b0;
    end else if (!go) begin
      state     <= DIV_IDLE;
      core_done <= 1'b0;
    end else begin
      case (state)
        DIV_IDLE: begin
          step <= '0;
          // Zero divisor skips the iterations
          if (zero_div) begin
            state     <= DIV_DONE;
            core_done <= 1'b1;
          end else begin
            state <= DIV_RUN;
          end
        end
        DIV_RUN: begin
          if (last) begin
            state     <= DIV_DONE;
            core_done <= 1'b1;
          end else begin
            step <= step + step_t'(1);
          end
        end
        DIV_DONE: begin
          core_done <= 1'b0;
        end
        default: begin
          state     <= DIV_IDLE;
          core_done <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      if (zero_div) begin
        quotient <= '0;
        rem      <= '0;
      end else begin
        dividend <= left;
        divisor  <= dword_t'(right) << (WORD_W - 1);
        quo_mask <= word_t'(1) << (WORD_W - 1);
        quo_acc  <= '0;
      end
    end else if (go && last) begin
      quotient <= quo_acc;
      rem      <= dividend;
    end else if (go && (state == DIV_RUN)) begin
      // One restoring step, MSB of the quotient first
      if (fits) begin
        dividend <= dividend - divisor[WORD_W-1:0];
        quo_acc  <= quo_acc | quo_mask;
      end
      divisor  <= divisor >> 1;
      quo_mask <= quo_mask >> 1;
    end
  end

endmodule

// File: div/div_pipe.sv
`timescale 1ns/1ps

module div_pipe
  import arith_fmt_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  go,
  input  logic  is_signed,
  input  word_t left,
  input  word_t right,
  output word_t quotient,
  output word_t rem,
  output logic  div_done
);

  logic  started;
  logic  start;
  logic  left_neg;
  logic  right_neg;
  word_t left_mag;
  word_t right_mag;

  logic  left_sign_q;
  logic  right_sign_q;
  word_t right_mag_q;

  word_t core_quotient;
  word_t core_rem;
  logic  core_done;
  logic  diff_signs;
  word_t rem_adj;

  // Sign bits are plain data bits in unsigned mode
  assign left_neg  = is_signed & left[WORD_W-1];
  assign right_neg = is_signed & right[WORD_W-1];
  assign left_mag  = left_neg ? -left : left;
  assign right_mag = right_neg ? -right : right;

  assign start = go & ~started;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      started <= 1'b0;
    end else if (!go) begin
      started <= 1'b0;
    end else if (start) begin
      started <= 1'b1;
    end
  end

  // Needed for the fix-up once the core is done
  always_ff @(posedge clk) begin
    if (start) begin
      left_sign_q  <= left_neg;
      right_sign_q <= right_neg;
      right_mag_q  <= right_mag;
    end
  end

  div_core u_div_core (
    .clk       (clk),
    .arst_n    (arst_n),
    .go        (go),
    .left      (left_mag),
    .right     (right_mag),
    .quotient  (core_quotient),
    .rem       (core_rem),
    .core_done (core_done)
  );

  assign diff_signs = left_sign_q ^ right_sign_q;

  // Quotient truncates toward zero
  assign quotient = diff_signs ? -core_quotient : core_quotient;

  // Remainder follows the divisor sign
  assign rem_adj  = (diff_signs && (core_rem != '0)) ? right_mag_q - core_rem : core_rem;
  assign rem      = right_sign_q ? -rem_adj : rem_adj;

  assign div_done = core_done;

endmodule

// File: mul/fx_mul_pipe.sv
`timescale 1ns/1ps

module fx_mul_pipe
  import arith_fmt_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  go,
  input  logic  fx,
  input  logic  is_signed,
  input  word_t left,
  input  word_t right,
  output word_t product,
  output logic  mul_done
);

  word_t  left_q;
  word_t  right_q;
  dword_t left_ext;
  dword_t right_ext;
  dword_t full_q;
  word_t  slice;

  logic [MUL_LATENCY-1:0] done_sr;
  logic                   chain_empty;

  assign chain_empty = ~|done_sr;
  assign mul_done    = done_sr[MUL_LATENCY-1];

  // A new token enters only when nothing is in flight
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done_sr <= '0;
    end else if (!go) begin
      done_sr <= '0;
    end else begin
      done_sr <= {done_sr[MUL_LATENCY-2:0], chain_empty};
    end
  end

  // Sign extension to full width gives the two's complement product
  always_comb begin
    if (is_signed) begin
      left_ext  = {{WORD_W{left_q[WORD_W-1]}}, left_q};
      right_ext = {{WORD_W{right_q[WORD_W-1]}}, right_q};
    end else begin
      left_ext  = {{WORD_W{1'b0}}, left_q};
      right_ext = {{WORD_W{1'b0}}, right_q};
    end
  end

  // Q8.8 times Q8.8 is Q16.16, keep the middle word
  always_comb begin
    if (fx) begin
      slice = full_q[2*WORD_W-INT_W-1:FRAC_W];
    end else begin
      slice = full_q[WORD_W-1:0];
    end
  end

  // Stages advance only while go is held, product keeps its value otherwise
  always_ff @(posedge clk) begin
    if (go) begin
      left_q  <= left;
      right_q <= right;
      full_q  <= left_ext * right_ext;
      product <= slice;
    end
  end

endmodule

// File: src/arith_unit.sv
`timescale 1ns/1ps

module arith_unit
  import arith_fmt_pkg::*;
  import arith_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  go,
  input  op_t   op,
  input  word_t left,
  input  word_t right,
  output word_t result,
  output word_t remainder,
  output logic  done
);

  logic busy;
  logic start;
  op_t  op_q;
  op_t  op_sel;

  logic is_mul;
  logic is_div;
  logic is_signed;
  logic fx;
  logic mul_go;
  logic div_go;

  word_t product;
  logic  mul_done;
  word_t quotient;
  word_t rem;
  logic  div_done;

  word_t done_result;
  word_t done_remainder;
  word_t result_q;
  word_t remainder_q;

  assign start = go & ~busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      op_q <= OP_MUL;
    end else if (start) begin
      busy <= 1'b1;
      op_q <= op;
    end else if (done || !go) begin
      busy <= 1'b0;
    end
  end

  // The captured op is not visible yet on the start edge itself
  assign op_sel = busy ? op_q : op;

  assign is_mul    = op_sel inside {OP_MUL, OP_FXMUL_U, OP_FXMUL_S};
  assign is_div    = op_sel inside {OP_DIV_U, OP_DIV_S};
  assign is_signed = op_sel inside {OP_FXMUL_S, OP_DIV_S};
  assign fx        = op_sel inside {OP_FXMUL_U, OP_FXMUL_S};

  assign mul_go = go & is_mul;
  assign div_go = go & is_div;

  fx_mul_pipe u_fx_mul_pipe (
    .clk       (clk),
    .arst_n    (arst_n),
    .go        (mul_go),
    .fx        (fx),
    .is_signed (is_signed),
    .left      (left),
    .right     (right),
    .product   (product),
    .mul_done  (mul_done)
  );

  div_pipe u_div_pipe (
    .clk       (clk),
    .arst_n    (arst_n),
    .go        (div_go),
    .is_signed (is_signed),
    .left      (left),
    .right     (right),
    .quotient  (quotient),
    .rem       (rem),
    .div_done  (div_done)
  );

  assign done = mul_done | div_done;

  // Multiplies carry no remainder
  assign done_result    = mul_done ? product : quotient;
  assign done_remainder = mul_done ? '0 : rem;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_q    <= '0;
      remainder_q <= '0;
    end else if (done) begin
      result_q    <= done_result;
      remainder_q <= done_remainder;
    end
  end

  // Live values in the done cycle, held copies afterwards
  assign result    = done ? done_result : result_q;
  assign remainder = done ? done_remainder : remainder_q;

endmodule

// File: test/arith_unit_sva.sv
`timescale 1ns/1ps

module arith_unit_sva
  import arith_fmt_pkg::*;
  import arith_ctrl_pkg::*;
(
  input logic clk,
  input logic arst_n,
  input logic go,
  input logic start,
  input op_t  op,
  input logic done
);

  int   fail_count = 0;
  logic mul_start;

  assign mul_start = start && (op inside {OP_MUL, OP_FXMUL_U, OP_FXMUL_S});

  a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
    else begin
      $error("done stayed high for more than one cycle");
      fail_count++;
    end

  a_done_needs_go: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(done) |-> $past(go))
    else begin
      $error("done rose without go on the previous edge");
      fail_count++;
    end

  a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !done)
    else begin
      $error("done high during reset");
      fail_count++;
    end

  // Multiply result comes out a fixed number of edges after the start edge
  a_mul_latency: assert property (@(posedge clk) disable iff (!arst_n)
    mul_start |=> !done [*(MUL_LATENCY-1)] ##1 done)
    else begin
      $error("multiply done not at the expected edge");
      fail_count++;
    end

endmodule

bind arith_unit arith_unit_sva u_sva (
  .clk    (clk),
  .arst_n (arst_n),
  .go     (go),
  .start  (start),
  .op     (op),
  .done   (done)
);

// File: test/arith_unit_tb.sv
`timescale 1ns/1ps

module arith_unit_tb
  import arith_fmt_pkg::*;
  import arith_ctrl_pkg::*;
();

  localparam int RESET_CYCLES = 8;
  localparam int N_MUL = 200;
  localparam int N_FX = 50;
  localparam int N_DIV = 50;
  localparam int N_OPS = N_MUL + 2 * N_FX + 4 + N_DIV + 3 + N_DIV + 4 + 4;
  localparam int TIMEOUT_CYCLES = N_OPS * (DIV_STEPS + 4) + RESET_CYCLES + 200;

  logic  clk;
  logic  arst_n;
  logic  go;
  op_t   op;
  word_t left;
  word_t right;
  word_t result;
  word_t remainder;
  logic  done;

  int    cycle = 0;
  int    errors = 0;
  int    checks = 0;
  int    tests = 0;
  word_t last_res;
  word_t last_rem;

  string name_q[$];
  word_t res_q[$];
  word_t rem_q[$];
  step_t lat_q[$];
  int    start_q[$];

  arith_unit DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .go        (go),
    .op        (op),
    .left      (left),
    .right     (right),
    .result    (result),
    .remainder (remainder),
    .done      (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // Expected values straight from the arithmetic definitions
  function automatic void ref_model(input op_t o, input word_t a, input word_t b,
                                    output word_t res, output word_t rem);
    longint ua;
    longint ub;
    longint sa;
    longint sb;
    longint p;
    longint q;
    longint r;
    ua = a;
    ub = b;
    sa = $signed(a);
    sb = $signed(b);
    res = '0;
    rem = '0;
    case (o)
      OP_MUL: begin
        p = ua * ub;
        res = word_t'(p);
      end
      OP_FXMUL_U: begin
        p = ua * ub;
        res = word_t'(p >> FRAC_W);
      end
      OP_FXMUL_S: begin
        p = sa * sb;
        res = word_t'(p >>> FRAC_W);
      end
      OP_DIV_U: begin
        if (ub != 0) begin
          res = word_t'(ua / ub);
          rem = word_t'(ua % ub);
        end
      end
      default: begin
        if (sb != 0) begin
          q = sa / sb;
          r = sa - sb * q;
          // Remainder takes the divisor's sign
          if ((r != 0) && ((r < 0) != (sb < 0))) r = r + sb;
          res = word_t'(q);
          rem = word_t'(r);
        end
      end
    endcase
  endfunction

  task automatic compare_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_latency(input string name, input step_t exp, input int act);
    checks++;
    if (int'(exp) != act) begin
      errors++;
      $display("MISMATCH %s latency expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic run_op(input string name, input op_t o, input word_t a, input word_t b);
    word_t exp_res;
    word_t exp_rem;
    step_t exp_lat;
    ref_model(o, a, b, exp_res, exp_rem);
    if (o inside {OP_DIV_U, OP_DIV_S}) exp_lat = (b == '0) ? step_t'(1) : step_t'(DIV_STEPS + 2);
    else exp_lat = step_t'(MUL_LATENCY);
    @(posedge clk);
    #1;
    go = 1'b1;
    op = o;
    left = a;
    right = b;
    name_q.push_back(name);
    res_q.push_back(exp_res);
    rem_q.push_back(exp_rem);
    lat_q.push_back(exp_lat);
    start_q.push_back(cycle);
    last_res = exp_res;
    last_rem = exp_rem;
    do @(negedge clk); while (!done);
    @(posedge clk);
    #1;
    go = 1'b0;
  endtask

  // Results must survive idle cycles while the op code wanders
  task automatic check_hold(input string name);
    op = op_t'($urandom_range(4, 0));
    repeat (3) @(negedge clk);
    compare_word({name, " held result"}, last_res, result);
    compare_word({name, " held remainder"}, last_rem, remainder);
  endtask

  task automatic report_test(input string name, input int err_before, input int ops);
    tests++;
    if (errors == err_before) $display("PASS %s (%0d operations)", name, ops);
    else $display("FAIL %s (%0d operations, %0d errors)", name, ops, errors - err_before);
  endtask

  initial begin
    string name;
    word_t res_exp;
    word_t rem_exp;
    step_t lat_exp;
    int    started;
    forever begin
      @(negedge clk);
      if (done) begin
        if (name_q.size() == 0) begin
          errors++;
          $display("ERROR: done pulsed with no operation in flight");
        end else begin
          name = name_q.pop_front();
          res_exp = res_q.pop_front();
          rem_exp = rem_q.pop_front();
          lat_exp = lat_q.pop_front();
          started = start_q.pop_front();
          compare_word({name, " result"}, res_exp, result);
          compare_word({name, " remainder"}, rem_exp, remainder);
          compare_latency(name, lat_exp, cycle - started);
        end
      end
    end
  end

  initial begin
    wait (cycle >= TIMEOUT_CYCLES);
    $display("ERROR: run timed out after %0d cycles", cycle);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int    err0;
    word_t a;
    word_t b;
    go = 1'b0;
    op = OP_MUL;
    left = '0;
    right = '0;
    arst_n = 1'b0;
    void'($urandom(68012));
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;

    err0 = errors;
    repeat (2) @(negedge clk);
    checks++;
    if (done !== 1'b0) begin
      errors++;
      $display("MISMATCH reset done expected 0 actual %b", done);
    end
    compare_word("reset result", '0, result);
    compare_word("reset remainder", '0, remainder);
    report_test("reset", err0, 0);

    err0 = errors;
    for (int i = 0; i < N_MUL; i++) run_op("mul", OP_MUL, word_t'($urandom), word_t'($urandom));
    report_test("mul", err0, N_MUL);

    err0 = errors;
    for (int i = 0; i < N_FX; i++) begin
      run_op("fxmul_u", OP_FXMUL_U, word_t'($urandom), word_t'($urandom));
    end
    report_test("fxmul_u", err0, N_FX);

    err0 = errors;
    run_op("fxmul_s neg*neg", OP_FXMUL_S, 16'hFE80, 16'hFD00);
    run_op("fxmul_s neg*pos", OP_FXMUL_S, 16'hFF40, 16'h0280);
    run_op("fxmul_s pos*neg", OP_FXMUL_S, 16'h0180, 16'h8000);
    run_op("fxmul_s neg*neg max", OP_FXMUL_S, 16'h8000, 16'h8000);
    for (int i = 0; i < N_FX; i++) begin
      run_op("fxmul_s", OP_FXMUL_S, word_t'($urandom), word_t'($urandom));
    end
    report_test("fxmul_s", err0, N_FX + 4);

    err0 = errors;
    run_op("div_u divisor larger", OP_DIV_U, 16'd5, 16'd1000);
    run_op("div_u divisor one", OP_DIV_U, 16'hBEEF, 16'd1);
    run_op("div_u max dividend", OP_DIV_U, 16'hFFFF, 16'd7);
    for (int i = 0; i < N_DIV; i++) begin
      a = word_t'($urandom);
      b = word_t'($urandom) >> $urandom_range(15, 0);
      run_op("div_u", OP_DIV_U, a, b);
    end
    report_test("div_u", err0, N_DIV + 3);

    err0 = errors;
    run_op("div_s pos/pos", OP_DIV_S, 16'd7, 16'd2);
    run_op("div_s neg/pos", OP_DIV_S, -16'sd7, 16'd2);
    run_op("div_s pos/neg", OP_DIV_S, 16'd7, -16'sd2);
    run_op("div_s neg/neg", OP_DIV_S, -16'sd7, -16'sd2);
    for (int i = 0; i < N_DIV; i++) begin
      a = word_t'($urandom_range(32767, 1));
      b = word_t'($urandom_range(1000, 1));
      if (i % 4 == 1 || i % 4 == 3) a = -a;
      if (i % 4 >= 2) b = -b;
      run_op("div_s", OP_DIV_S, a, b);
    end
    report_test("div_s", err0, N_DIV + 4);

    err0 = errors;
    run_op("div_u by zero", OP_DIV_U, 16'h1234, 16'd0);
    check_hold("div_u by zero");
    run_op("div_s by zero", OP_DIV_S, -16'sd300, 16'd0);
    check_hold("div_s by zero");
    run_op("mul before hold", OP_MUL, 16'h0123, 16'h0045);
    check_hold("mul");
    run_op("div_s after mul", OP_DIV_S, -16'sd1000, 16'd3);
    check_hold("div_s");
    report_test("div_zero_and_hold", err0, 4);

    repeat (2) @(posedge clk);
    errors += DUT.u_sva.fail_count;
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
